//--- src/ccu_consts.svh
// Width and depth constants for the communications unit, included by RTL and testbench
`ifndef CCU_CONSTS_SVH
`define CCU_CONSTS_SVH

// Byte address width
`define CCU_ADDR_WIDTH 32

// Bus word and lookup word width
`define CCU_WORD_WIDTH 32

// Words in one cache line
`define CCU_LINE_WORDS 4

// Queue depths, victim depth a power of two
`define CCU_VQ_DEPTH   4
`define CCU_IFQ_DEPTH  2

// Derived byte counts
`define CCU_WORD_BYTES (`CCU_WORD_WIDTH / 8)
`define CCU_LINE_BYTES (`CCU_LINE_WORDS * `CCU_WORD_BYTES)

`endif

//--- src/ccu_pkg.sv
// Shared line, request, fill and state types used by every communications unit block
`include "ccu_consts.svh"

package ccu_pkg;

    // Word 0 sits in the low bits
    typedef logic [`CCU_LINE_WORDS-1:0][`CCU_WORD_WIDTH-1:0] ccu_line_t;

    typedef enum logic {
        CCU_FUNC_READ  = 1'b0,
        CCU_FUNC_WRITE = 1'b1
    } ccu_func_e;

    // One line request, queue to arbiter or arbiter to bus master
    typedef struct packed {
        ccu_func_e                  func;
        logic [`CCU_ADDR_WIDTH-1:0] addr;
        ccu_line_t                  line;
    } ccu_req_t;

    typedef enum logic [1:0] {
        CCU_BUS_IDLE = 2'b00,
        CCU_BUS_BEAT = 2'b01,
        CCU_BUS_DONE = 2'b10
    } ccu_bus_state_e;

    // Filled line back to the instruction cache
    typedef struct packed {
        logic [`CCU_ADDR_WIDTH-1:0] addr;
        ccu_line_t                  data;
    } ccu_fill_t;

endpackage

//--- src/ccu_victim_queue.sv
// Victim queue holding dirty lines for write-back and forwarding words to load lookups
`timescale 1ns/1ps
`include "ccu_consts.svh"

module ccu_victim_queue import ccu_pkg::*; (
    input  logic                       clk,
    input  logic                       i_reset,

    input  logic                       i_victim_valid,
    input  logic [`CCU_ADDR_WIDTH-1:0] i_victim_addr,
    input  ccu_line_t                  i_victim_line,

    input  logic [`CCU_ADDR_WIDTH-1:0] i_lookup_addr,
    output logic                       o_lookup_hit,
    output logic [`CCU_WORD_WIDTH-1:0] o_lookup_data,

    output logic                       o_vq_full,

    output logic                       o_ccu_en,
    output ccu_req_t                   o_ccu_req,
    input  logic                       i_ccu_done
);

    localparam int DEPTH    = `CCU_VQ_DEPTH;
    localparam int IDX_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int ADDR_W   = `CCU_ADDR_WIDTH;
    localparam int LINE_OFF = $clog2(`CCU_LINE_BYTES);
    localparam int WORD_OFF = $clog2(`CCU_WORD_BYTES);

    logic [IDX_W-1:0]  head;
    logic [IDX_W-1:0]  tail;
    logic [DEPTH-1:0]  entry_valid;
    logic [ADDR_W-1:0] entry_addr [DEPTH];
    ccu_line_t         entry_line [DEPTH];

    logic [LINE_OFF-WORD_OFF-1:0] word_sel;

    // Slot at tail still occupied means every slot is taken
    assign o_vq_full = entry_valid[tail];

    // Oldest entry is always offered for write-back
    assign o_ccu_en       = entry_valid[head];
    assign o_ccu_req.func = CCU_FUNC_WRITE;
    assign o_ccu_req.addr = entry_addr[head];
    assign o_ccu_req.line = entry_line[head];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            head        <= '0;
            tail        <= '0;
            entry_valid <= '0;
        end else begin
            if (i_victim_valid) begin
                entry_valid[tail] <= 1'b1;
                tail              <= tail + 1'b1;
            end
            if (i_ccu_done) begin
                entry_valid[head] <= 1'b0;
                head              <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_victim_valid) begin
            entry_addr[tail] <= {i_victim_addr[ADDR_W-1:LINE_OFF], {LINE_OFF{1'b0}}};
            entry_line[tail] <= i_victim_line;
        end
    end

    assign word_sel = i_lookup_addr[LINE_OFF-1:WORD_OFF];

    // Scan oldest to newest so the newest hit wins
    always_comb begin : lookup
        logic [IDX_W-1:0] idx;
        o_lookup_hit  = 1'b0;
        o_lookup_data = '0;
        for (int i = 0; i < DEPTH; i++) begin
            idx = head + IDX_W'(i);
            if (entry_valid[idx] &&
                entry_addr[idx][ADDR_W-1:LINE_OFF] == i_lookup_addr[ADDR_W-1:LINE_OFF]) begin
                o_lookup_hit  = 1'b1;
                o_lookup_data = entry_line[idx][word_sel];
            end
        end
    end

    vq_no_push_full: assert property (@(posedge clk) disable iff (i_reset)
        i_victim_valid |-> !o_vq_full)
        else $error("victim enqueued while queue full");

    vq_done_owned: assert property (@(posedge clk) disable iff (i_reset)
        i_ccu_done |-> o_ccu_en)
        else $error("victim done without pending request");

endmodule

//--- src/ccu_fetch_queue.sv
// Fetch queue of instruction miss lines, issuing bus reads and delivering fills to the icache
`timescale 1ns/1ps
`include "ccu_consts.svh"

module ccu_fetch_queue import ccu_pkg::*; (
    input  logic                       clk,
    input  logic                       i_reset,

    input  logic                       i_ifq_alloc_en,
    input  logic [`CCU_ADDR_WIDTH-1:0] i_ifq_alloc_addr,
    output logic                       o_ifq_full,

    output logic                       o_ccu_en,
    output ccu_req_t                   o_ccu_req,
    input  logic                       i_ccu_done,
    input  ccu_line_t                  i_ccu_line,

    output logic                       o_ifq_fill_en,
    output ccu_fill_t                  o_ifq_fill
);

    localparam int DEPTH    = `CCU_IFQ_DEPTH;
    localparam int IDX_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W    = $clog2(DEPTH + 1);
    localparam int ADDR_W   = `CCU_ADDR_WIDTH;
    localparam int LINE_OFF = $clog2(`CCU_LINE_BYTES);

    logic [IDX_W-1:0]  head;
    logic [IDX_W-1:0]  tail;
    logic [CNT_W-1:0]  count;
    logic [ADDR_W-1:0] miss_addr [DEPTH];

    assign o_ifq_full = (count == CNT_W'(DEPTH));

    // Head miss goes out as a line read
    assign o_ccu_en       = (count != '0);
    assign o_ccu_req.func = CCU_FUNC_READ;
    assign o_ccu_req.addr = miss_addr[head];
    assign o_ccu_req.line = '0;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            head          <= '0;
            tail          <= '0;
            count         <= '0;
            o_ifq_fill_en <= 1'b0;
        end else begin
            o_ifq_fill_en <= i_ccu_done;
            if (i_ifq_alloc_en) begin
                tail <= (tail == IDX_W'(DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (i_ccu_done) begin
                head <= (head == IDX_W'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            case ({i_ifq_alloc_en, i_ccu_done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_ifq_alloc_en) begin
            miss_addr[tail] <= {i_ifq_alloc_addr[ADDR_W-1:LINE_OFF], {LINE_OFF{1'b0}}};
        end
        // Fill payload captured with its address on done
        if (i_ccu_done) begin
            o_ifq_fill.addr <= miss_addr[head];
            o_ifq_fill.data <= i_ccu_line;
        end
    end

    ifq_no_alloc_full: assert property (@(posedge clk) disable iff (i_reset)
        i_ifq_alloc_en |-> !o_ifq_full)
        else $error("fetch miss allocated while queue full");

endmodule

//--- src/ccu_arbiter.sv
// Fixed-priority arbiter granting the bus master to the victim queue or the fetch queue
`timescale 1ns/1ps
`include "ccu_consts.svh"

module ccu_arbiter import ccu_pkg::*; (
    input  logic      clk,
    input  logic      i_reset,

    input  logic      i_vq_en,
    input  ccu_req_t  i_vq_req,
    output logic      o_vq_done,

    input  logic      i_ifq_en,
    input  ccu_req_t  i_ifq_req,
    output logic      o_ifq_done,
    output ccu_line_t o_ifq_line,

    output logic      o_biu_en,
    output ccu_req_t  o_biu_req,
    input  logic      i_biu_done,
    input  ccu_line_t i_biu_line
);

    logic     busy;
    logic     owner_ifq;
    logic     grant;
    ccu_req_t grant_req;

    // Victim queue wins ties so reads never pass pending write-backs
    assign grant = !busy && (i_vq_en || i_ifq_en);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            busy      <= 1'b0;
            owner_ifq <= 1'b0;
        end else if (grant) begin
            busy      <= 1'b1;
            owner_ifq <= !i_vq_en;
        end else if (i_biu_done) begin
            busy      <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            grant_req <= i_vq_en ? i_vq_req : i_ifq_req;
        end
    end

    assign o_biu_en  = busy;
    assign o_biu_req = grant_req;

    // Done goes back to the owner only
    assign o_vq_done  = i_biu_done && !owner_ifq;
    assign o_ifq_done = i_biu_done && owner_ifq;
    assign o_ifq_line = i_biu_line;

    arb_done_when_busy: assert property (@(posedge clk) disable iff (i_reset)
        i_biu_done |-> busy)
        else $error("bus master done with no granted request");

endmodule

//--- src/ccu_bus_master.sv
// Bus master splitting each line request into word beats on the external bus
`timescale 1ns/1ps
`include "ccu_consts.svh"

module ccu_bus_master import ccu_pkg::*; (
    input  logic                       clk,
    input  logic                       i_reset,

    input  logic                       i_biu_en,
    input  ccu_req_t                   i_biu_req,
    output logic                       o_biu_done,
    output ccu_line_t                  o_biu_line,

    input  logic                       i_bus_ack,
    input  logic [`CCU_WORD_WIDTH-1:0] i_bus_data,
    output logic                       o_bus_cyc,
    output logic                       o_bus_stb,
    output logic                       o_bus_we,
    output logic [`CCU_ADDR_WIDTH-1:0] o_bus_addr,
    output logic [`CCU_WORD_WIDTH-1:0] o_bus_data
);

    localparam int WORDS  = `CCU_LINE_WORDS;
    localparam int BEAT_W = $clog2(WORDS);
    localparam int ADDR_W = `CCU_ADDR_WIDTH;

    ccu_bus_state_e    state;
    logic [BEAT_W-1:0] beat;
    logic              start;
    logic              beat_ack;
    logic              last_beat;
    ccu_line_t         wr_line;
    ccu_line_t         rd_line;

    assign start     = (state == CCU_BUS_IDLE) && i_biu_en;
    assign beat_ack  = (state == CCU_BUS_BEAT) && i_bus_ack;
    assign last_beat = (beat == BEAT_W'(WORDS - 1));

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state     <= CCU_BUS_IDLE;
            beat      <= '0;
            o_bus_cyc <= 1'b0;
            o_bus_stb <= 1'b0;
            o_bus_we  <= 1'b0;
        end else begin
            case (state)
                CCU_BUS_IDLE: begin
                    if (i_biu_en) begin
                        state     <= CCU_BUS_BEAT;
                        beat      <= '0;
                        o_bus_cyc <= 1'b1;
                        o_bus_stb <= 1'b1;
                        o_bus_we  <= (i_biu_req.func == CCU_FUNC_WRITE);
                    end
                end
                CCU_BUS_BEAT: begin
                    if (i_bus_ack) begin
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            state     <= CCU_BUS_DONE;
                            o_bus_cyc <= 1'b0;
                            o_bus_stb <= 1'b0;
                            o_bus_we  <= 1'b0;
                        end
                    end
                end
                CCU_BUS_DONE: state <= CCU_BUS_IDLE;
                default:      state <= CCU_BUS_IDLE;
            endcase
        end
    end

    // Address and write word step forward on every ack
    always_ff @(posedge clk) begin
        if (start) begin
            wr_line    <= i_biu_req.line;
            o_bus_addr <= i_biu_req.addr;
            o_bus_data <= i_biu_req.line[0];
        end else if (beat_ack) begin
            o_bus_addr <= o_bus_addr + ADDR_W'(`CCU_WORD_BYTES);
            o_bus_data <= wr_line[beat + 1'b1];
            rd_line    <= {i_bus_data, rd_line[WORDS-1:1]};
        end
    end

    assign o_biu_done = (state == CCU_BUS_DONE);
    assign o_biu_line = rd_line;

    bus_stb_in_cyc: assert property (@(posedge clk) disable iff (i_reset)
        o_bus_stb |-> o_bus_cyc)
        else $error("strobe raised outside a bus cycle");

endmodule

//--- src/ccu_top.sv
// Communications unit top level joining the victim queue, fetch queue, arbiter and bus master
`timescale 1ns/1ps
`include "ccu_consts.svh"

module ccu_top import ccu_pkg::*; (
    input  logic                       clk,
    input  logic                       i_reset,

    input  logic                       i_victim_valid,
    input  logic [`CCU_ADDR_WIDTH-1:0] i_victim_addr,
    input  ccu_line_t                  i_victim_line,
    input  logic [`CCU_ADDR_WIDTH-1:0] i_lookup_addr,
    output logic                       o_lookup_hit,
    output logic [`CCU_WORD_WIDTH-1:0] o_lookup_data,
    output logic                       o_vq_full,

    input  logic                       i_ifq_alloc_en,
    input  logic [`CCU_ADDR_WIDTH-1:0] i_ifq_alloc_addr,
    output logic                       o_ifq_full,
    output logic                       o_ifq_fill_en,
    output ccu_fill_t                  o_ifq_fill,

    input  logic                       i_bus_ack,
    input  logic [`CCU_WORD_WIDTH-1:0] i_bus_data,
    output logic                       o_bus_cyc,
    output logic                       o_bus_stb,
    output logic                       o_bus_we,
    output logic [`CCU_ADDR_WIDTH-1:0] o_bus_addr,
    output logic [`CCU_WORD_WIDTH-1:0] o_bus_data
);

    logic      vq_en;
    ccu_req_t  vq_req;
    logic      vq_done;
    logic      ifq_en;
    ccu_req_t  ifq_req;
    logic      ifq_done;
    ccu_line_t ifq_line;
    logic      biu_en;
    ccu_req_t  biu_req;
    logic      biu_done;
    ccu_line_t biu_line;

    ccu_victim_queue ccu_victim_queue_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_victim_valid(i_victim_valid),
        .i_victim_addr(i_victim_addr),
        .i_victim_line(i_victim_line),
        .i_lookup_addr(i_lookup_addr),
        .o_lookup_hit(o_lookup_hit),
        .o_lookup_data(o_lookup_data),
        .o_vq_full(o_vq_full),
        .o_ccu_en(vq_en),
        .o_ccu_req(vq_req),
        .i_ccu_done(vq_done)
    );

    ccu_fetch_queue ccu_fetch_queue_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_ifq_alloc_en(i_ifq_alloc_en),
        .i_ifq_alloc_addr(i_ifq_alloc_addr),
        .o_ifq_full(o_ifq_full),
        .o_ccu_en(ifq_en),
        .o_ccu_req(ifq_req),
        .i_ccu_done(ifq_done),
        .i_ccu_line(ifq_line),
        .o_ifq_fill_en(o_ifq_fill_en),
        .o_ifq_fill(o_ifq_fill)
    );

    ccu_arbiter ccu_arbiter_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_vq_en(vq_en),
        .i_vq_req(vq_req),
        .o_vq_done(vq_done),
        .i_ifq_en(ifq_en),
        .i_ifq_req(ifq_req),
        .o_ifq_done(ifq_done),
        .o_ifq_line(ifq_line),
        .o_biu_en(biu_en),
        .o_biu_req(biu_req),
        .i_biu_done(biu_done),
        .i_biu_line(biu_line)
    );

    ccu_bus_master ccu_bus_master_inst (
        .clk(clk),
        .i_reset(i_reset),
        .i_biu_en(biu_en),
        .i_biu_req(biu_req),
        .o_biu_done(biu_done),
        .o_biu_line(biu_line),
        .i_bus_ack(i_bus_ack),
        .i_bus_data(i_bus_data),
        .o_bus_cyc(o_bus_cyc),
        .o_bus_stb(o_bus_stb),
        .o_bus_we(o_bus_we),
        .o_bus_addr(o_bus_addr),
        .o_bus_data(o_bus_data)
    );

endmodule

//--- tb/tb_clock.sv
// Free-running clock source for the testbench, instantiated once by the testbench top
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 10.0
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) o_clk = ~o_clk;
        end
    end

endmodule

//--- tb/ccu_tb.sv
// Self-checking testbench for the communications unit, acting as bus slave with reference queues
`timescale 1ns/1ps
`include "ccu_consts.svh"

module ccu_tb import ccu_pkg::*; ();

    localparam int ADDR_W     = `CCU_ADDR_WIDTH;
    localparam int WORD_W     = `CCU_WORD_WIDTH;
    localparam int LINE_OFF   = $clog2(`CCU_LINE_BYTES);
    localparam int WORD_OFF   = $clog2(`CCU_WORD_BYTES);
    localparam int MEM_WORDS  = 64;
    localparam int MEM_IDX_W  = $clog2(MEM_WORDS);
    localparam int N_VICTIMS  = 40;
    localparam int N_FETCHES  = 30;
    localparam int MAX_CYCLES = 20000;
    localparam logic [ADDR_W-1:0] REGION = 'h1000;

    // Inputs prepared for the next cycle
    typedef struct packed {
        logic              victim_valid;
        logic [ADDR_W-1:0] victim_addr;
        ccu_line_t         victim_line;
        logic [ADDR_W-1:0] lookup_addr;
        logic              alloc_en;
        logic [ADDR_W-1:0] alloc_addr;
        logic              ack;
        logic [WORD_W-1:0] data;
    } stim_t;

    logic              clk;
    logic              i_reset;
    logic              i_victim_valid;
    logic [ADDR_W-1:0] i_victim_addr;
    ccu_line_t         i_victim_line;
    logic [ADDR_W-1:0] i_lookup_addr;
    logic              o_lookup_hit;
    logic [WORD_W-1:0] o_lookup_data;
    logic              o_vq_full;
    logic              i_ifq_alloc_en;
    logic [ADDR_W-1:0] i_ifq_alloc_addr;
    logic              o_ifq_full;
    logic              o_ifq_fill_en;
    ccu_fill_t         o_ifq_fill;
    logic              i_bus_ack;
    logic [WORD_W-1:0] i_bus_data;
    logic              o_bus_cyc;
    logic              o_bus_stb;
    logic              o_bus_we;
    logic [ADDR_W-1:0] o_bus_addr;
    logic [WORD_W-1:0] o_bus_data;

    integer            seed;
    stim_t             nx;
    logic [ADDR_W-1:0] vq_addr [$];
    ccu_line_t         vq_line [$];
    logic [ADDR_W-1:0] ifq_addr [$];
    logic [WORD_W-1:0] mem [MEM_WORDS];
    logic              mem_valid [MEM_WORDS];
    int                victims_sent;
    int                fetches_sent;
    int                lines_moved;
    int                wait_cnt;
    int                beat;
    logic              in_txn;
    logic              txn_write;
    logic              done_pending;
    logic              fill_due;
    logic              empty_d1;
    logic              empty_d2;
    logic              arb_busy;
    logic              grant_d1;
    logic              grant_d2;
    ccu_line_t         rd_gather;
    ccu_fill_t         exp_fill;

    tb_clock clock_gen (.o_clk(clk));

    ccu_top dut0 (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_line(input string name, input ccu_line_t got, input ccu_line_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_fill(input string name, input ccu_fill_t got, input ccu_fill_t exp);
        check_addr({name, ".addr"}, got.addr, exp.addr);
        check_line({name, ".data"}, got.data, exp.data);
    endtask

    function automatic logic [ADDR_W-1:0] line_align(input logic [ADDR_W-1:0] addr);
        return addr & ~ADDR_W'(`CCU_LINE_BYTES - 1);
    endfunction

    // Untouched words follow a pattern of the full address
    function automatic logic [WORD_W-1:0] mem_read(input logic [ADDR_W-1:0] addr);
        int idx;
        idx = int'(addr[WORD_OFF +: MEM_IDX_W]);
        return mem_valid[idx] ? mem[idx] : (WORD_W'(addr) ^ 32'hA5C3_0F96);
    endfunction

    task automatic mem_write(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
        int idx;
        idx = int'(addr[WORD_OFF +: MEM_IDX_W]);
        mem[idx]       = data;
        mem_valid[idx] = 1'b1;
    endtask

    // Newest matching entry supplies the word
    task automatic model_lookup(input logic [ADDR_W-1:0] addr, output logic hit,
                                output logic [WORD_W-1:0] data);
        hit  = 1'b0;
        data = '0;
        for (int i = 0; i < vq_addr.size(); i++) begin
            if (vq_addr[i][ADDR_W-1:LINE_OFF] == addr[ADDR_W-1:LINE_OFF]) begin
                hit  = 1'b1;
                data = vq_line[i][addr[LINE_OFF-1:WORD_OFF]];
            end
        end
    endtask

    function automatic logic run_finished();
        return victims_sent == N_VICTIMS && fetches_sent == N_FETCHES &&
               vq_addr.size() == 0 && ifq_addr.size() == 0 &&
               !in_txn && !done_pending && !fill_due;
    endfunction

    task automatic observe_cycle();
        logic              hit;
        logic [WORD_W-1:0] word;
        logic [ADDR_W-1:0] exp_addr;
        logic              vq_empty_now;
        logic              done_now;
        logic              grant_now;
        logic              exp_stb;
        vq_empty_now = (vq_addr.size() == 0);
        done_now     = done_pending;
        done_pending = 1'b0;
        // Arbiter grants when idle and either queue holds a line
        grant_now    = !arb_busy && (!vq_empty_now || ifq_addr.size() != 0);
        exp_stb      = in_txn || grant_d2;

        check_flag("o_vq_full", o_vq_full, vq_addr.size() == `CCU_VQ_DEPTH);
        check_flag("o_ifq_full", o_ifq_full, ifq_addr.size() == `CCU_IFQ_DEPTH);
        model_lookup(i_lookup_addr, hit, word);
        check_flag("o_lookup_hit", o_lookup_hit, hit);
        if (hit) begin
            check_word("o_lookup_data", o_lookup_data, word);
        end
        check_flag("o_ifq_fill_en", o_ifq_fill_en, fill_due);
        if (fill_due) begin
            check_fill("o_ifq_fill", o_ifq_fill, exp_fill);
            fill_due = 1'b0;
        end
        check_flag("o_bus_stb", o_bus_stb, exp_stb);
        check_flag("o_bus_cyc", o_bus_cyc, exp_stb);

        if (exp_stb) begin
            if (!in_txn) begin
                // Grant was taken two cycles before the strobe rose
                txn_write = !empty_d2;
                in_txn    = 1'b1;
                beat      = 0;
            end
            check_flag("o_bus_we", o_bus_we, txn_write);
            if (i_bus_ack) begin
                if (txn_write) begin
                    exp_addr = vq_addr[0] + ADDR_W'(beat * `CCU_WORD_BYTES);
                    check_addr("o_bus_addr", o_bus_addr, exp_addr);
                    check_word("o_bus_data", o_bus_data, vq_line[0][beat]);
                    mem_write(exp_addr, vq_line[0][beat]);
                end else begin
                    exp_addr = ifq_addr[0] + ADDR_W'(beat * `CCU_WORD_BYTES);
                    check_addr("o_bus_addr", o_bus_addr, exp_addr);
                    rd_gather[beat] = i_bus_data;
                end
                beat++;
                if (beat == `CCU_LINE_WORDS) begin
                    in_txn       = 1'b0;
                    done_pending = 1'b1;
                end
            end
        end

        // DONE cycle retires the owner's entry at the coming edge
        if (done_now) begin
            if (txn_write) begin
                vq_addr.delete(0);
                vq_line.delete(0);
            end else begin
                exp_fill.addr = ifq_addr[0];
                exp_fill.data = rd_gather;
                ifq_addr.delete(0);
                fill_due      = 1'b1;
            end
            lines_moved++;
        end
        if (i_victim_valid) begin
            vq_addr.push_back(line_align(i_victim_addr));
            vq_line.push_back(i_victim_line);
        end
        if (i_ifq_alloc_en) begin
            ifq_addr.push_back(line_align(i_ifq_alloc_addr));
        end
        if (grant_now) begin
            arb_busy = 1'b1;
        end else if (done_now) begin
            arb_busy = 1'b0;
        end
        grant_d2 = grant_d1;
        grant_d1 = grant_now;
        empty_d2 = empty_d1;
        empty_d1 = vq_empty_now;
    endtask

    task automatic plan_inputs();
        logic [31:0] r;
        r = $random(seed);
        nx.victim_valid = (vq_addr.size() < `CCU_VQ_DEPTH) && (victims_sent < N_VICTIMS) &&
                          (r[3:0] == 4'd0);
        nx.alloc_en     = (ifq_addr.size() < `CCU_IFQ_DEPTH) && (fetches_sent < N_FETCHES) &&
                          (r[7:4] == 4'd0);
        if (nx.victim_valid) begin
            victims_sent++;
        end
        if (nx.alloc_en) begin
            fetches_sent++;
        end
        // Small address pool so lookups and reads meet written lines
        nx.victim_addr = REGION | (ADDR_W'($random(seed)) & 'hFF);
        nx.victim_line = {$random(seed), $random(seed), $random(seed), $random(seed)};
        nx.alloc_addr  = REGION | (ADDR_W'($random(seed)) & 'hFF);
        nx.lookup_addr = REGION | (ADDR_W'($random(seed)) & 'hFC);

        // Slave acks each beat after 0 to 3 idle cycles
        nx.ack  = 1'b0;
        nx.data = '0;
        if (o_bus_stb && !i_bus_ack) begin
            if (wait_cnt < 0) begin
                wait_cnt = $unsigned($random(seed)) % 4;
            end
            if (wait_cnt == 0) begin
                nx.ack   = 1'b1;
                nx.data  = mem_read(o_bus_addr);
                wait_cnt = -1;
            end else begin
                wait_cnt--;
            end
        end
    endtask

    task automatic drive_inputs();
        i_victim_valid   <= nx.victim_valid;
        i_victim_addr    <= nx.victim_addr;
        i_victim_line    <= nx.victim_line;
        i_lookup_addr    <= nx.lookup_addr;
        i_ifq_alloc_en   <= nx.alloc_en;
        i_ifq_alloc_addr <= nx.alloc_addr;
        i_bus_ack        <= nx.ack;
        i_bus_data       <= nx.data;
    endtask

    initial begin
        ccu_bus_state_e bus_state;
        int             cycles;
        logic           finished;
        seed             = 32'h9cc8;
        nx               = '0;
        i_reset          = 1'b1;
        i_victim_valid   = 1'b0;
        i_victim_addr    = '0;
        i_victim_line    = '0;
        i_lookup_addr    = '0;
        i_ifq_alloc_en   = 1'b0;
        i_ifq_alloc_addr = '0;
        i_bus_ack        = 1'b0;
        i_bus_data       = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_valid[i] = 1'b0;
        end
        victims_sent = 0;
        fetches_sent = 0;
        lines_moved  = 0;
        wait_cnt     = -1;
        beat         = 0;
        in_txn       = 1'b0;
        txn_write    = 1'b0;
        done_pending = 1'b0;
        fill_due     = 1'b0;
        empty_d1     = 1'b1;
        empty_d2     = 1'b1;
        arb_busy     = 1'b0;
        grant_d1     = 1'b0;
        grant_d2     = 1'b0;
        rd_gather    = '0;
        exp_fill     = '0;

        repeat (5) @(posedge clk);
        i_reset <= 1'b0;
        @(negedge clk);
        check_flag("o_bus_cyc", o_bus_cyc, 1'b0);
        check_flag("o_bus_stb", o_bus_stb, 1'b0);
        check_flag("o_ifq_fill_en", o_ifq_fill_en, 1'b0);
        check_flag("o_vq_full", o_vq_full, 1'b0);
        check_flag("o_ifq_full", o_ifq_full, 1'b0);

        cycles   = 0;
        finished = 1'b0;
        while (!finished && cycles < MAX_CYCLES) begin
            observe_cycle();
            finished = run_finished();
            plan_inputs();
            @(posedge clk);
            drive_inputs();
            @(negedge clk);
            cycles++;
        end

        if (finished) begin
            $display("%0d line transfers checked in %0d cycles", lines_moved, cycles);
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            bus_state = dut0.ccu_bus_master_inst.state;
            abort_run($sformatf("Timeout after %0d cycles with the bus master in state %s",
                                cycles, bus_state.name()));
        end
    end

endmodule

//--- src.f
+incdir+src
src/ccu_pkg.sv
src/ccu_victim_queue.sv
src/ccu_fetch_queue.sv
src/ccu_arbiter.sv
src/ccu_bus_master.sv
src/ccu_top.sv
tb/tb_clock.sv
tb/ccu_tb.sv
